/* Makefile */
# Verilator build and run of the controller sniffer testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module ctrl_sniffer_tb \
		-f filelist.f -Mdir obj_dir -o Vctrl_sniffer_tb
	./obj_dir/Vctrl_sniffer_tb | tee $(LOG)
	@grep -q "^All checks passed$$" $(LOG) || (echo "simulation reported failure"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* filelist.f */
hw/ctrl_proto_pkg.sv
hw/ctrl_cfg_pkg.sv
hw/ctrl_bit_sampler.sv
hw/ctrl_frame_decoder.sv
hw/ctrl_word_mailbox.sv
hw/igr_reset_driver.sv
hw/ctrl_sniffer_top.sv
tb/ctrl_sniffer_tb.sv

/* hw/ctrl_bit_sampler.sv */
//////////////////////////////
// Pulse-width bit recovery for the N64 controller line.
// Synchronises the line, times low and high phases and closes
// one bit per low/high pair, either at the next falling edge or
// at a virtual edge when the line stays high.
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module ctrl_bit_sampler (
  input  wire  CTRL_CLK,
  input  wire  CTRL_nRST,
  input  wire  ctrl_line_i,
  output logic bit_stb_o,
  output logic bit_val_o,
  output logic frame_start_o,
  output logic line_timeout_o
);

  logic [2:0] line_hist;   // [0],[1] sync, [2] previous
  logic [7:0] width_cnt;   // cycles since last edge, saturating
  logic [7:0] low_width;   // low time of the current bit
  logic       last_rise;   // last edge seen was a rising one
  logic       fall_edge;
  logic       rise_edge;
  logic       cnt_sat;

  assign fall_edge = line_hist[2] & ~line_hist[1];
  assign rise_edge = ~line_hist[2] & line_hist[1];
  assign cnt_sat   = (width_cnt == ctrl_proto_pkg::WAIT_SAT);

  always_ff @(posedge CTRL_CLK or negedge CTRL_nRST) begin
    if (!CTRL_nRST) begin
      line_hist <= 3'b111;   // idle line is high
      width_cnt <= 8'd0;
      low_width <= 8'd0;
      last_rise <= 1'b0;
    end else begin
      line_hist <= {line_hist[1:0], ctrl_line_i};

      if (fall_edge || rise_edge) begin
        width_cnt <= 8'd0;
      end else if (!cnt_sat) begin
        width_cnt <= width_cnt + 8'd1;
      end

      if (rise_edge) begin
        low_width <= width_cnt;  // low phase just ended
        last_rise <= 1'b1;
      end else if (fall_edge) begin
        last_rise <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // bit closing
  //////////////////////////////

  // early falling edge, or high long enough for a virtual one
  assign bit_stb_o = last_rise &
    ((fall_edge & (width_cnt < ctrl_proto_pkg::VIRT_EDGE_TH)) |
     (width_cnt == ctrl_proto_pkg::VIRT_EDGE_TH));
  assign bit_val_o = (low_width < width_cnt); // short low means 1

  assign frame_start_o  = fall_edge & cnt_sat;
  assign line_timeout_o = cnt_sat;

  a_stb_excl: assert property (@(posedge CTRL_CLK) disable iff (!CTRL_nRST)
    !(bit_stb_o && frame_start_o))
    else $error("bit strobe and frame start in the same cycle");

endmodule

`default_nettype wire

/* hw/ctrl_cfg_pkg.sv */
//////////////////////////////
// Button masks and timing for the controller features.
// Masks apply to the low 16 bits of a received controller word,
// where bit k is the k-th data bit on the line.
//////////////////////////////

`default_nettype none

package ctrl_cfg_pkg;

  localparam int unsigned COMBO_BITS = 16;  // buttons only, no stick axes

  // single buttons
  localparam logic [COMBO_BITS-1:0] BTN_A     = 16'h0001;
  localparam logic [COMBO_BITS-1:0] BTN_B     = 16'h0002;
  localparam logic [COMBO_BITS-1:0] BTN_Z     = 16'h0004;
  localparam logic [COMBO_BITS-1:0] BTN_START = 16'h0008;
  localparam logic [COMBO_BITS-1:0] BTN_L     = 16'h0400;
  localparam logic [COMBO_BITS-1:0] BTN_R     = 16'h0800;

  //////////////////////////////
  // combinations
  //////////////////////////////

  // A+B+Z+Start+L+R, console reset request
  localparam logic [COMBO_BITS-1:0] IGR_RESET =
    BTN_A | BTN_B | BTN_Z | BTN_START | BTN_L | BTN_R;

  // Start+L+R held at power-up selects fallback mode
  localparam logic [COMBO_BITS-1:0] IGR_FALLBACK = BTN_START | BTN_L | BTN_R;

  // length of the reset pulse in CTRL_CLK cycles
  localparam logic [19:0] RST_HOLD_CYCLES = 20'hFFFFF;

endpackage

`default_nettype wire

/* hw/ctrl_frame_decoder.sv */
//////////////////////////////
// Frame decoder for the sniffed controller line.
// Decodes the console command byte, then collects either the
// 32-bit poll response or the 80-bit game-id message. A frame is
// only taken over when its stop bit reads 1.
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module ctrl_frame_decoder (
  input  wire                                             CTRL_CLK,
  input  wire                                             CTRL_nRST,
  input  wire                                             bit_stb_i,
  input  wire                                             bit_val_i,
  input  wire                                             frame_start_i,
  input  wire                                             line_timeout_i,
  output logic                                            word_stb_o,
  output logic [ctrl_proto_pkg::CTRL_WORD_BITS-1:0]       word_data_o,
  output logic                                            ctrl_detected_o,
  output logic [ctrl_proto_pkg::GAME_ID_BITS-1:0]         game_id_o
);

  ctrl_proto_pkg::rd_state_e rd_state;
  ctrl_proto_pkg::bit_cnt_t  data_cnt;
  ctrl_proto_pkg::bit_cnt_t  gid_idx;

  logic [ctrl_proto_pkg::CMD_BITS-1:0]       cmd_sr;
  logic [ctrl_proto_pkg::CTRL_WORD_BITS-1:0] word_sr;
  logic [ctrl_proto_pkg::GAME_ID_BITS-1:0]   gid_buf;

  logic cmd_done;    // ninth strobe of the command phase
  logic cmd_bit_we;
  logic word_bit_we;
  logic gid_bit_we;
  logic ctrl_stop;   // stop bit after the poll response
  logic gid_stop;    // stop bit after the game id

  //////////////////////////////
  // strobe qualification
  //////////////////////////////

  always_comb begin
    cmd_done    = bit_stb_i && (rd_state == ctrl_proto_pkg::RD_CMD) &&
                  (data_cnt == ctrl_proto_pkg::CMD_CNT);
    cmd_bit_we  = bit_stb_i && (rd_state == ctrl_proto_pkg::RD_CMD) &&
                  (data_cnt < ctrl_proto_pkg::CMD_CNT);
    word_bit_we = bit_stb_i && (rd_state == ctrl_proto_pkg::RD_CTRL) &&
                  (data_cnt < ctrl_proto_pkg::WORD_CNT);
    ctrl_stop   = bit_stb_i && (rd_state == ctrl_proto_pkg::RD_CTRL) &&
                  (data_cnt == ctrl_proto_pkg::WORD_CNT);
    gid_stop    = bit_stb_i && (rd_state == ctrl_proto_pkg::RD_GAME_ID) &&
                  (data_cnt == ctrl_proto_pkg::GID_CNT);
    // the ninth command bit already belongs to the game id
    gid_bit_we  = (cmd_done && (cmd_sr == ctrl_proto_pkg::CMD_GAME_ID)) ||
                  (bit_stb_i && (rd_state == ctrl_proto_pkg::RD_GAME_ID) &&
                   (data_cnt < ctrl_proto_pkg::GID_CNT));
    gid_idx     = (rd_state == ctrl_proto_pkg::RD_CMD) ? '0 : data_cnt;
  end

  // shift buffers, first bit received in bit 0
  always_ff @(posedge CTRL_CLK) begin
    if (cmd_bit_we) begin
      cmd_sr[data_cnt[2:0]] <= bit_val_i;
    end
    if (word_bit_we) begin
      word_sr[data_cnt[4:0]] <= bit_val_i;
    end
    if (gid_bit_we) begin
      gid_buf[gid_idx] <= bit_val_i;
    end
  end

  //////////////////////////////
  // state machine
  //////////////////////////////

  always_ff @(posedge CTRL_CLK or negedge CTRL_nRST) begin
    if (!CTRL_nRST) begin
      rd_state        <= ctrl_proto_pkg::RD_WAIT;
      data_cnt        <= '0;
      word_stb_o      <= 1'b0;
      word_data_o     <= '0;
      ctrl_detected_o <= 1'b0;
      game_id_o       <= '0;
    end else begin
      word_stb_o <= 1'b0;

      case (rd_state)
        ctrl_proto_pkg::RD_WAIT: begin
          if (frame_start_i) begin
            rd_state <= ctrl_proto_pkg::RD_CMD;
            data_cnt <= '0;
          end
        end
        ctrl_proto_pkg::RD_CMD: begin
          if (cmd_bit_we) begin
            data_cnt <= data_cnt + 1'b1;
          end else if (cmd_done) begin
            if (cmd_sr == ctrl_proto_pkg::CMD_POLL) begin
              rd_state <= ctrl_proto_pkg::RD_CTRL;
              data_cnt <= '0;
            end else if (cmd_sr == ctrl_proto_pkg::CMD_GAME_ID) begin
              rd_state <= ctrl_proto_pkg::RD_GAME_ID;
              data_cnt <= ctrl_proto_pkg::bit_cnt_t'(1);  // bit 0 taken now
            end else begin
              rd_state <= ctrl_proto_pkg::RD_WAIT;   // not for us
            end
          end
        end
        ctrl_proto_pkg::RD_CTRL: begin
          if (word_bit_we) begin
            data_cnt <= data_cnt + 1'b1;
          end else if (ctrl_stop) begin
            rd_state        <= ctrl_proto_pkg::RD_WAIT;
            ctrl_detected_o <= bit_val_i;
            if (bit_val_i) begin
              word_stb_o  <= 1'b1;
              word_data_o <= word_sr;
            end
          end
        end
        ctrl_proto_pkg::RD_GAME_ID: begin
          if (gid_bit_we) begin
            data_cnt <= data_cnt + 1'b1;
          end else if (gid_stop) begin
            rd_state <= ctrl_proto_pkg::RD_WAIT;
            if (bit_val_i) begin
              // byte n in [8n+7:8n], first received bit is its MSB
              for (int n = 0; n < ctrl_proto_pkg::GAME_ID_BYTES; n++) begin
                for (int b = 0; b < 8; b++) begin
                  game_id_o[8*n + 7 - b] <= gid_buf[8*n + b];
                end
              end
            end
          end
        end
        default: rd_state <= ctrl_proto_pkg::RD_WAIT;
      endcase

      // line idle too long, abort whatever is running
      if (line_timeout_i && !frame_start_i) begin
        if (rd_state == ctrl_proto_pkg::RD_CMD) begin
          ctrl_detected_o <= 1'b0;
        end
        rd_state <= ctrl_proto_pkg::RD_WAIT;
      end
    end
  end

  a_cnt_bound: assert property (@(posedge CTRL_CLK) disable iff (!CTRL_nRST)
    data_cnt <= ctrl_proto_pkg::GID_CNT)
    else $error("data bit count above game-id length");

endmodule

`default_nettype wire

/* hw/ctrl_proto_pkg.sv */
//////////////////////////////
// N64 controller line protocol definitions.
// Command codes as seen by the sniffer, pulse-width thresholds
// in CTRL_CLK cycles, frame lengths and the decoder state encoding.
// Referenced by scoped names from the sampler and the decoder.
//////////////////////////////

`default_nettype none

package ctrl_proto_pkg;

  //////////////////////////////
  // command bytes
  //////////////////////////////

  // stored first bit in bit 0, so the console byte appears reversed
  localparam logic [7:0] CMD_POLL    = 8'h80;  // console 0x01
  localparam logic [7:0] CMD_GAME_ID = 8'hB8;  // console 0x1D

  //////////////////////////////
  // bit timing
  //////////////////////////////

  localparam logic [7:0] WAIT_SAT     = 8'd255; // idle time before a frame, also frame abort
  localparam logic [7:0] VIRT_EDGE_TH = 8'd32;  // close a bit without a falling edge

  //////////////////////////////
  // frame lengths
  //////////////////////////////

  localparam int unsigned CMD_BITS       = 8;
  localparam int unsigned CTRL_WORD_BITS = 32;
  localparam int unsigned GAME_ID_BITS   = 80;
  localparam int unsigned GAME_ID_BYTES  = GAME_ID_BITS / 8;

  // data bit counter, wide enough for the game-id frame
  localparam int unsigned CNT_W = 7;
  typedef logic [CNT_W-1:0] bit_cnt_t;

  localparam bit_cnt_t CMD_CNT  = bit_cnt_t'(CMD_BITS);
  localparam bit_cnt_t WORD_CNT = bit_cnt_t'(CTRL_WORD_BITS);
  localparam bit_cnt_t GID_CNT  = bit_cnt_t'(GAME_ID_BITS);

  // decoder states
  typedef enum logic [1:0] {
    RD_WAIT    = 2'b00,  // idle, waiting for a console request
    RD_CMD     = 2'b01,  // console command byte
    RD_CTRL    = 2'b10,  // controller poll response
    RD_GAME_ID = 2'b11   // game-id message
  } rd_state_e;

endpackage

`default_nettype wire

/* hw/ctrl_sniffer_top.sv */
//////////////////////////////
// Controller sniffer top level.
// Bit sampler feeds the frame decoder, accepted words go to the
// CPU mailbox and to the in-game reset driver.
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module ctrl_sniffer_top (
  input  wire                                        CTRL_CLK,
  input  wire                                        CTRL_nRST,
  input  wire                                        ctrl_line_i,
  input  wire                                        ack_toggle_i,
  input  wire                                        igr_enable_i,
  output logic [ctrl_proto_pkg::CTRL_WORD_BITS-1:0]  ctrl_word_o,
  output logic                                       new_data_o,
  output logic                                       ctrl_detected_o,
  output logic [ctrl_proto_pkg::GAME_ID_BITS-1:0]    game_id_o,
  output logic                                       fallback_valid_o,
  output logic                                       fallback_o,
  output logic                                       nrst_drive_o
);

  // sampler to decoder
  logic bit_stb;
  logic bit_val;
  logic frame_start;
  logic line_timeout;

  // accepted controller words
  logic                                      word_stb;
  logic [ctrl_proto_pkg::CTRL_WORD_BITS-1:0] word_data;

  ctrl_bit_sampler u_sampler (
    .CTRL_CLK       (CTRL_CLK),
    .CTRL_nRST      (CTRL_nRST),
    .ctrl_line_i    (ctrl_line_i),
    .bit_stb_o      (bit_stb),
    .bit_val_o      (bit_val),
    .frame_start_o  (frame_start),
    .line_timeout_o (line_timeout)
  );

  ctrl_frame_decoder u_decoder (
    .CTRL_CLK        (CTRL_CLK),
    .CTRL_nRST       (CTRL_nRST),
    .bit_stb_i       (bit_stb),
    .bit_val_i       (bit_val),
    .frame_start_i   (frame_start),
    .line_timeout_i  (line_timeout),
    .word_stb_o      (word_stb),
    .word_data_o     (word_data),
    .ctrl_detected_o (ctrl_detected_o),
    .game_id_o       (game_id_o)
  );

  ctrl_word_mailbox u_mailbox (
    .CTRL_CLK         (CTRL_CLK),
    .CTRL_nRST        (CTRL_nRST),
    .word_stb_i       (word_stb),
    .word_data_i      (word_data),
    .ack_toggle_i     (ack_toggle_i),
    .ctrl_word_o      (ctrl_word_o),
    .new_data_o       (new_data_o),
    .fallback_valid_o (fallback_valid_o),
    .fallback_o       (fallback_o)
  );

  igr_reset_driver u_igr (
    .CTRL_CLK     (CTRL_CLK),
    .CTRL_nRST    (CTRL_nRST),
    .word_stb_i   (word_stb),
    .word_data_i  (word_data),
    .igr_enable_i (igr_enable_i),
    .nrst_drive_o (nrst_drive_o)
  );

endmodule

`default_nettype wire

/* hw/ctrl_word_mailbox.sv */
//////////////////////////////
// Mailbox for the latest controller word.
// A new word sets the new-data flag, a toggle on the acknowledge
// from the reader clock domain clears it. The first word after
// reset also decides the fallback mode once.
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module ctrl_word_mailbox (
  input  wire                                        CTRL_CLK,
  input  wire                                        CTRL_nRST,
  input  wire                                        word_stb_i,
  input  wire  [ctrl_proto_pkg::CTRL_WORD_BITS-1:0]  word_data_i,
  input  wire                                        ack_toggle_i,
  output logic [ctrl_proto_pkg::CTRL_WORD_BITS-1:0]  ctrl_word_o,
  output logic                                       new_data_o,
  output logic                                       fallback_valid_o,
  output logic                                       fallback_o
);

  logic [1:0] ack_sync;    // two-flop synchroniser
  logic       ack_sync_d;  // previous synchronised level
  logic       ack_edge;

  assign ack_edge = ack_sync[1] ^ ack_sync_d;  // either toggle direction

  always_ff @(posedge CTRL_CLK or negedge CTRL_nRST) begin
    if (!CTRL_nRST) begin
      ack_sync         <= 2'b00;
      ack_sync_d       <= 1'b0;
      ctrl_word_o      <= '0;
      new_data_o       <= 1'b0;
      fallback_valid_o <= 1'b0;
      fallback_o       <= 1'b0;
    end else begin
      ack_sync   <= {ack_sync[0], ack_toggle_i};
      ack_sync_d <= ack_sync[1];

      // an unread word is simply overwritten
      if (word_stb_i) begin
        ctrl_word_o <= word_data_i;
        new_data_o  <= 1'b1;
      end else if (ack_edge) begin
        new_data_o <= 1'b0;
      end

      // one-shot decision on the first word
      if (word_stb_i && !fallback_valid_o) begin
        fallback_valid_o <= 1'b1;
        fallback_o       <= (word_data_i[ctrl_cfg_pkg::COMBO_BITS-1:0] ==
                             ctrl_cfg_pkg::IGR_FALLBACK);
      end
    end
  end

  a_new_rise: assert property (@(posedge CTRL_CLK) disable iff (!CTRL_nRST)
    $rose(new_data_o) |-> $past(word_stb_i))
    else $error("new data flag rose without a word strobe");

endmodule

`default_nettype wire

/* hw/igr_reset_driver.sv */
//////////////////////////////
// In-game reset. When enabled and the reset combination arrives
// in an accepted word, the console reset is driven for a fixed
// hold time. The output is the enable of the open-drain pad.
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module igr_reset_driver (
  input  wire                                        CTRL_CLK,
  input  wire                                        CTRL_nRST,
  input  wire                                        word_stb_i,
  input  wire  [ctrl_proto_pkg::CTRL_WORD_BITS-1:0]  word_data_i,
  input  wire                                        igr_enable_i,
  output logic                                       nrst_drive_o
);

  logic [1:0]  en_sync;   // enable comes from the config side
  logic [19:0] hold_cnt;
  logic        combo_hit;

  assign combo_hit = word_stb_i && en_sync[1] &&
    (word_data_i[ctrl_cfg_pkg::COMBO_BITS-1:0] == ctrl_cfg_pkg::IGR_RESET);

  always_ff @(posedge CTRL_CLK or negedge CTRL_nRST) begin
    if (!CTRL_nRST) begin
      en_sync      <= 2'b00;
      hold_cnt     <= 20'd0;
      nrst_drive_o <= 1'b0;
    end else begin
      en_sync <= {en_sync[0], igr_enable_i};

      if (combo_hit) begin
        hold_cnt     <= ctrl_cfg_pkg::RST_HOLD_CYCLES;  // restart on every hit
        nrst_drive_o <= 1'b1;
      end else if (hold_cnt != 20'd0) begin
        hold_cnt <= hold_cnt - 20'd1;
      end else begin
        nrst_drive_o <= 1'b0;   // hold time over
      end
    end
  end

  a_drive_hold: assert property (@(posedge CTRL_CLK) disable iff (!CTRL_nRST)
    nrst_drive_o |-> (hold_cnt != 20'd0) || $past(hold_cnt == 20'd1))
    else $error("reset driven with hold counter expired");

endmodule

`default_nettype wire

/* tb/ctrl_sniffer_tb.sv */
//////////////////////////////
// Directed testbench for the controller sniffer.
// A line model drives console commands and controller replies by
// pulse width, one task per test checks the decoded outputs.
// Prints one line per test and the error counts at the end.
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module ctrl_sniffer_tb;

  localparam int CLK_HALF      = 50;   // 100 ns period
  localparam int RESET_CYCLES  = 10;
  localparam int IDLE_CYCLES   = 300;  // longer than the sampler saturation
  localparam int SHORT_PHASE   = 8;
  localparam int LONG_PHASE    = 24;
  localparam int STB_TIMEOUT   = 200;  // frame end to output change
  localparam int ACK_TIMEOUT   = 16;

  // console command bytes as sent on the line
  localparam logic [7:0] CONSOLE_POLL    = 8'h01;
  localparam logic [7:0] CONSOLE_GAME_ID = 8'h1D;
  localparam logic [7:0] CONSOLE_INFO    = 8'h00;  // ignored by the sniffer

  // flag selectors for the wait loop
  localparam int SEL_NEW_DATA = 0;
  localparam int SEL_DETECTED = 1;
  localparam int SEL_NRST     = 2;

  logic        CTRL_CLK;
  logic        CTRL_nRST;
  logic        ctrl_line;
  logic        ack_toggle;
  logic        igr_enable;
  logic [31:0] ctrl_word;
  logic        new_data;
  logic        ctrl_detected;
  logic [79:0] game_id;
  logic        fallback_valid;
  logic        fallback;
  logic        nrst_drive;

  integer seed = 25071;
  int     errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     test_err_start = 0;

  ctrl_sniffer_top dut (
    .CTRL_CLK         (CTRL_CLK),
    .CTRL_nRST        (CTRL_nRST),
    .ctrl_line_i      (ctrl_line),
    .ack_toggle_i     (ack_toggle),
    .igr_enable_i     (igr_enable),
    .ctrl_word_o      (ctrl_word),
    .new_data_o       (new_data),
    .ctrl_detected_o  (ctrl_detected),
    .game_id_o        (game_id),
    .fallback_valid_o (fallback_valid),
    .fallback_o       (fallback),
    .nrst_drive_o     (nrst_drive)
  );

  initial begin
    CTRL_CLK = 1'b0;
    forever #CLK_HALF CTRL_CLK = ~CTRL_CLK;
  end

  //////////////////////////////
  // bookkeeping
  //////////////////////////////

  task automatic count_mismatch(input string test, input string what,
                                input logic [79:0] exp, input logic [79:0] act);
    $display("ERR %s %s expected %0h actual %0h", test, what, exp, act);
    errors++;
  endtask

  task automatic note_problem(input string test, input string text);
    $display("%s: %s", test, text);
    errors++;
  endtask

  task automatic start_test();
    test_err_start = errors;
    tests_run++;
  endtask

  task automatic close_test(input string test);
    if (errors == test_err_start) begin
      $display("test %s ok", test);
    end else begin
      $display("test %s failed with %0d errors", test, errors - test_err_start);
      tests_failed++;
    end
  endtask

  //////////////////////////////
  // line model
  //////////////////////////////

  task automatic hold_line(input logic level, input int cycles);
    ctrl_line = level;
    repeat (cycles) @(negedge CTRL_CLK);
  endtask

  // short low is a 1, long low is a 0
  task automatic drive_bit(input logic b);
    hold_line(1'b0, b ? SHORT_PHASE : LONG_PHASE);
    hold_line(1'b1, b ? LONG_PHASE : SHORT_PHASE);
  endtask

  task automatic shift_out_byte(input logic [7:0] data);
    for (int i = 7; i >= 0; i--) begin
      drive_bit(data[i]);  // MSB first
    end
  endtask

  // a 0 stop bit needs a following falling edge to be closed
  task automatic close_frame(input logic stop);
    drive_bit(stop);
    if (!stop) begin
      drive_bit(1'b1);
    end
  endtask

  // console command with its stop bit, then the 32-bit reply
  task automatic response_frame(input logic [7:0] cmd, input logic [31:0] word,
                                input logic stop);
    hold_line(1'b1, IDLE_CYCLES);
    shift_out_byte(cmd);
    drive_bit(1'b1);
    for (int k = 0; k < 32; k++) begin
      drive_bit(word[k]);  // bit 0 first
    end
    close_frame(stop);
  endtask

  // byte n of gid sits in gid[8n+7:8n]
  task automatic game_id_frame(input logic [79:0] gid);
    hold_line(1'b1, IDLE_CYCLES);
    shift_out_byte(CONSOLE_GAME_ID);
    for (int n = 0; n < 10; n++) begin
      shift_out_byte(gid[8*n +: 8]);
    end
    close_frame(1'b1);
  endtask

  //////////////////////////////
  // waits and resets
  //////////////////////////////

  function automatic logic sample_flag(input int sel);
    case (sel)
      SEL_NEW_DATA: return new_data;
      SEL_DETECTED: return ctrl_detected;
      default:      return nrst_drive;
    endcase
  endfunction

  task automatic wait_for_level(input string test, input string what, input int sel,
                                input logic level, input int limit, output logic ok);
    int cycles;
    cycles = 0;
    while (sample_flag(sel) !== level && cycles < limit) begin
      @(negedge CTRL_CLK);
      cycles++;
    end
    ok = (sample_flag(sel) === level);
    if (!ok) begin
      $display("%s: %s did not go to %0d within %0d cycles", test, what, level, limit);
      errors++;
    end
  endtask

  task automatic acknowledge_word(input string test);
    logic ok;
    ack_toggle = ~ack_toggle;
    wait_for_level(test, "new_data_o", SEL_NEW_DATA, 1'b0, ACK_TIMEOUT, ok);
  endtask

  task automatic apply_reset();
    CTRL_nRST = 1'b0;
    repeat (RESET_CYCLES) @(negedge CTRL_CLK);
    CTRL_nRST = 1'b1;
    @(negedge CTRL_CLK);
  endtask

  task automatic expect_reset_values(input string test);
    if (new_data !== 1'b0)
      count_mismatch(test, "new_data_o", 80'(0), 80'(new_data));
    if (ctrl_detected !== 1'b0)
      count_mismatch(test, "ctrl_detected_o", 80'(0), 80'(ctrl_detected));
    if (fallback_valid !== 1'b0)
      count_mismatch(test, "fallback_valid_o", 80'(0), 80'(fallback_valid));
    if (fallback !== 1'b0)
      count_mismatch(test, "fallback_o", 80'(0), 80'(fallback));
    if (nrst_drive !== 1'b0)
      count_mismatch(test, "nrst_drive_o", 80'(0), 80'(nrst_drive));
    if (ctrl_word !== 32'd0)
      count_mismatch(test, "ctrl_word_o", 80'(0), 80'(ctrl_word));
    if (game_id !== 80'd0)
      count_mismatch(test, "game_id_o", 80'(0), game_id);
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic after_reset();
    start_test();
    expect_reset_values("after_reset");
    close_test("after_reset");
  endtask

  task automatic poll_capture();
    string       test;
    logic [31:0] word;
    logic        ok;
    test = "poll_capture";
    start_test();
    word = $random(seed);
    if (new_data !== 1'b0)
      note_problem(test, "new_data_o was already high before the frame");
    response_frame(CONSOLE_POLL, word, 1'b1);
    wait_for_level(test, "new_data_o", SEL_NEW_DATA, 1'b1, STB_TIMEOUT, ok);
    if (ok && ctrl_word !== word)
      count_mismatch(test, "ctrl_word_o", 80'(word), 80'(ctrl_word));
    if (ok && ctrl_detected !== 1'b1)
      count_mismatch(test, "ctrl_detected_o", 80'(1), 80'(ctrl_detected));
    close_test(test);
  endtask

  task automatic ack_clears_flag();
    string       test;
    logic [31:0] held_word;
    test = "ack_clears_flag";
    start_test();
    held_word = ctrl_word;
    acknowledge_word(test);
    if (ctrl_word !== held_word)
      count_mismatch(test, "ctrl_word_o", 80'(held_word), 80'(ctrl_word));
    close_test(test);
  endtask

  task automatic unknown_command();
    string       test;
    logic [31:0] held_word;
    logic        held_det;
    logic [79:0] held_gid;
    test = "unknown_command";
    start_test();
    held_word = ctrl_word;
    held_det  = ctrl_detected;
    held_gid  = game_id;
    response_frame(CONSOLE_INFO, $random(seed), 1'b1);
    hold_line(1'b1, IDLE_CYCLES);  // nothing to wait for, just watch
    if (ctrl_word !== held_word)
      count_mismatch(test, "ctrl_word_o", 80'(held_word), 80'(ctrl_word));
    if (new_data !== 1'b0)
      count_mismatch(test, "new_data_o", 80'(0), 80'(new_data));
    if (ctrl_detected !== held_det)
      count_mismatch(test, "ctrl_detected_o", 80'(held_det), 80'(ctrl_detected));
    if (game_id !== held_gid)
      count_mismatch(test, "game_id_o", held_gid, game_id);
    close_test(test);
  endtask

  task automatic bad_stop_bit();
    string       test;
    logic [31:0] held_word;
    logic        ok;
    test = "bad_stop_bit";
    start_test();
    held_word = ctrl_word;
    response_frame(CONSOLE_POLL, $random(seed), 1'b0);
    wait_for_level(test, "ctrl_detected_o", SEL_DETECTED, 1'b0, STB_TIMEOUT, ok);
    hold_line(1'b1, STB_TIMEOUT);
    if (new_data !== 1'b0)
      count_mismatch(test, "new_data_o", 80'(0), 80'(new_data));
    if (ctrl_word !== held_word)
      count_mismatch(test, "ctrl_word_o", 80'(held_word), 80'(ctrl_word));
    close_test(test);
  endtask

  task automatic game_id_capture();
    string       test;
    logic [79:0] gid;
    logic [79:0] prev_gid;
    int          cycles;
    test = "game_id_capture";
    start_test();
    gid      = 80'h9B12_C35A_807E_FE01_3CA5;  // byte 0 is A5
    prev_gid = game_id;
    game_id_frame(gid);
    cycles = 0;
    while (game_id === prev_gid && cycles < STB_TIMEOUT) begin
      @(negedge CTRL_CLK);
      cycles++;
    end
    if (game_id === prev_gid)
      note_problem(test, "game_id_o did not change after the frame");
    else if (game_id !== gid)
      count_mismatch(test, "game_id_o", gid, game_id);
    close_test(test);
  endtask

  task automatic combo_without_enable();
    string       test;
    logic [31:0] word;
    logic        ok;
    test = "combo_without_enable";
    start_test();
    igr_enable = 1'b0;
    word = $random(seed);
    word = {word[31:16], ctrl_cfg_pkg::IGR_RESET};
    response_frame(CONSOLE_POLL, word, 1'b1);
    wait_for_level(test, "new_data_o", SEL_NEW_DATA, 1'b1, STB_TIMEOUT, ok);
    if (nrst_drive !== 1'b0)
      count_mismatch(test, "nrst_drive_o", 80'(0), 80'(nrst_drive));
    acknowledge_word(test);
    close_test(test);
  endtask

  task automatic console_reset_drive();
    string       test;
    logic [31:0] word;
    logic        ok;
    int          hold;
    int          held;
    test = "console_reset_drive";
    start_test();
    hold = int'(ctrl_cfg_pkg::RST_HOLD_CYCLES);
    igr_enable = 1'b1;
    word = $random(seed);
    word = {word[31:16], ctrl_cfg_pkg::IGR_RESET};
    response_frame(CONSOLE_POLL, word, 1'b1);
    wait_for_level(test, "nrst_drive_o", SEL_NRST, 1'b1, STB_TIMEOUT, ok);
    if (ok) begin
      held = 0;
      while (nrst_drive === 1'b1 && held <= hold + 100) begin
        @(negedge CTRL_CLK);
        held++;
      end
      if (nrst_drive !== 1'b0)
        note_problem(test, "nrst_drive_o still high after the hold time ran out");
      else if (held < hold || held > hold + 2)
        count_mismatch(test, "reset hold cycles", 80'(hold), 80'(held));
    end
    acknowledge_word(test);
    igr_enable = 1'b0;
    close_test(test);
  endtask

  task automatic fallback_latch();
    string       test;
    logic [31:0] first_word;
    logic [31:0] later_word;
    logic        ok;
    test = "fallback_latch";
    start_test();
    apply_reset();
    expect_reset_values(test);
    first_word = $random(seed);
    first_word = {first_word[31:16], ctrl_cfg_pkg::IGR_FALLBACK};
    response_frame(CONSOLE_POLL, first_word, 1'b1);
    wait_for_level(test, "new_data_o", SEL_NEW_DATA, 1'b1, STB_TIMEOUT, ok);
    if (fallback_valid !== 1'b1)
      count_mismatch(test, "fallback_valid_o", 80'(1), 80'(fallback_valid));
    if (fallback !== 1'b1)
      count_mismatch(test, "fallback_o", 80'(1), 80'(fallback));
    acknowledge_word(test);

    // a different word later must not move the decision
    later_word = $random(seed);
    later_word = {later_word[31:16], ctrl_cfg_pkg::BTN_A};
    response_frame(CONSOLE_POLL, later_word, 1'b1);
    wait_for_level(test, "new_data_o", SEL_NEW_DATA, 1'b1, STB_TIMEOUT, ok);
    if (ok && ctrl_word !== later_word)
      count_mismatch(test, "ctrl_word_o", 80'(later_word), 80'(ctrl_word));
    if (fallback_valid !== 1'b1)
      count_mismatch(test, "fallback_valid_o", 80'(1), 80'(fallback_valid));
    if (fallback !== 1'b1)
      count_mismatch(test, "fallback_o", 80'(1), 80'(fallback));
    acknowledge_word(test);
    close_test(test);
  endtask

  //////////////////////////////
  // sequence
  //////////////////////////////

  initial begin
    ctrl_line  = 1'b1;  // idle line
    ack_toggle = 1'b0;
    igr_enable = 1'b0;
    CTRL_nRST  = 1'b0;
    apply_reset();

    after_reset();
    poll_capture();
    ack_clears_flag();
    unknown_command();
    bad_stop_bit();
    game_id_capture();
    combo_without_enable();
    console_reset_drive();
    fallback_latch();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
